// ==== rtl/alu_pkg.sv ====
package alu_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////////////////////////

	localparam int data_width = 32;
	localparam int shamt_width = 5; // Enough for any shift of a data word.
	localparam int op_width = 5;
	localparam int cmp_width = 2;

	//////////////////////////////////////////////////////////////////////
	// Opcodes
	//////////////////////////////////////////////////////////////////////

	localparam logic [op_width-1:0] op_add = 5'd0;
	localparam logic [op_width-1:0] op_sub = 5'd1;
	localparam logic [op_width-1:0] op_and = 5'd2;
	localparam logic [op_width-1:0] op_or = 5'd3;
	localparam logic [op_width-1:0] op_not = 5'd4; // Uses num1 only.
	localparam logic [op_width-1:0] op_xor = 5'd5;
	localparam logic [op_width-1:0] op_movz = 5'd6; // Passes num1.
	localparam logic [op_width-1:0] op_nor = 5'd7;
	localparam logic [op_width-1:0] op_slt = 5'd8;
	localparam logic [op_width-1:0] op_sltu = 5'd9;

	// Immediate shifts, amount from shamt.
	localparam logic [op_width-1:0] op_sll = 5'd10;
	localparam logic [op_width-1:0] op_srl = 5'd11;
	localparam logic [op_width-1:0] op_sra = 5'd12;

	// Variable shifts, amount from the low bits of num1.
	localparam logic [op_width-1:0] op_sllv = 5'd13;
	localparam logic [op_width-1:0] op_srlv = 5'd14;
	localparam logic [op_width-1:0] op_srav = 5'd15;

	// Codes 16 and up are not defined.

	//////////////////////////////////////////////////////////////////////
	// Compare codes
	//////////////////////////////////////////////////////////////////////

	localparam logic [cmp_width-1:0] cmp_equal = 2'd0;
	localparam logic [cmp_width-1:0] cmp_smaller = 2'd1; // num1 below num2.
	localparam logic [cmp_width-1:0] cmp_larger = 2'd2;

endpackage

// ==== rtl/alu.sv ====
module alu (
	input  logic [alu_pkg::data_width-1:0]  num1,
	input  logic [alu_pkg::data_width-1:0]  num2,
	input  logic [alu_pkg::shamt_width-1:0] shamt,
	input  logic [alu_pkg::op_width-1:0]    op,
	output logic [alu_pkg::data_width-1:0]  result,
	output logic [alu_pkg::cmp_width-1:0]   cmp_result,
	output logic [alu_pkg::cmp_width-1:0]   sig_cmp_result,
	output logic                            overflow,
	output logic                            op_invalid
);
	import alu_pkg::*;

	logic [shamt_width-1:0] sh_amt;
	logic [data_width:0] sum_ext;
	logic [data_width:0] diff_ext;
	logic [data_width-1:0] sll_val;
	logic [data_width-1:0] srl_val;
	logic [data_width-1:0] sra_val;
	logic slt_bit;
	logic sltu_bit;

	//////////////////////////////////////////////////////////////////////
	// Shifter
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (op)
			op_sllv, op_srlv, op_srav: sh_amt = num1[shamt_width-1:0];
			default: sh_amt = shamt;
		endcase
	end

	assign sll_val = num2 << sh_amt;
	assign srl_val = num2 >> sh_amt;
	assign sra_val = $signed(num2) >>> sh_amt; // Sign fill.

	//////////////////////////////////////////////////////////////////////
	// Adder and set-less-than
	//////////////////////////////////////////////////////////////////////

	// One extra bit keeps the carry or borrow.
	assign sum_ext = {1'b0, num1} + {1'b0, num2};
	assign diff_ext = {1'b0, num1} - {1'b0, num2};

	assign slt_bit = $signed(num1) < $signed(num2);
	assign sltu_bit = num1 < num2;

	//////////////////////////////////////////////////////////////////////
	// Result select
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		result = '0;
		op_invalid = 1'b0;
		case (op)
			op_add: result = sum_ext[data_width-1:0];
			op_sub: result = diff_ext[data_width-1:0];
			op_and: result = num1 & num2;
			op_or: result = num1 | num2;
			op_not: result = ~num1;
			op_xor: result = num1 ^ num2;
			op_movz: result = num1;
			op_nor: result = ~(num1 | num2);
			op_slt: result = {{(data_width-1){1'b0}}, slt_bit};
			op_sltu: result = {{(data_width-1){1'b0}}, sltu_bit};
			op_sll, op_sllv: result = sll_val;
			op_srl, op_srlv: result = srl_val;
			op_sra, op_srav: result = sra_val;
			default: op_invalid = 1'b1; // Result stays zero.
		endcase
	end

	always_comb begin
		case (op)
			op_add: overflow = sum_ext[data_width];
			op_sub: overflow = diff_ext[data_width];
			default: overflow = 1'b0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Three-way compare, valid for every opcode
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		if (num1 == num2) begin
			cmp_result = cmp_equal;
		end else if (sltu_bit) begin
			cmp_result = cmp_smaller;
		end else begin
			cmp_result = cmp_larger;
		end
	end

	always_comb begin
		if (num1 == num2) begin
			sig_cmp_result = cmp_equal;
		end else if (slt_bit) begin
			sig_cmp_result = cmp_smaller;
		end else begin
			sig_cmp_result = cmp_larger;
		end
	end

endmodule

// ==== rtl/alu_arbiter.sv ====
module alu_arbiter (
	input  logic clk,
	input  logic reset,
	input  logic req_a,
	input  logic req_b,
	output logic grant_a,
	output logic grant_b
);

	logic last_b; // Set when b took the last grant.
	logic elig_a;
	logic elig_b;
	logic pick_a;
	logic pick_b;

	// A port granted this cycle still shows its request. Skip it.
	assign elig_a = req_a & ~grant_a;
	assign elig_b = req_b & ~grant_b;

	// On a tie the loser of the last round goes first.
	assign pick_a = elig_a & (~elig_b | last_b);
	assign pick_b = elig_b & (~elig_a | ~last_b);

	always_ff @(posedge clk) begin
		if (reset) begin
			grant_a <= 1'b0;
			grant_b <= 1'b0;
			last_b <= 1'b0;
		end else begin
			grant_a <= pick_a;
			grant_b <= pick_b;
			if (pick_a | pick_b) begin
				last_b <= pick_b;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	one_grant: assert property (
		@(posedge clk) disable iff (reset)
		!(grant_a && grant_b)
	) else $error("Both ALU grants high in the same cycle.");

endmodule

// ==== rtl/alu_port.sv ====
module alu_port (
	input  logic                             clk,
	input  logic                             reset,
	input  logic                             req,
	input  logic [alu_pkg::op_width-1:0]     op,
	input  logic [alu_pkg::data_width-1:0]   num1,
	input  logic [alu_pkg::data_width-1:0]   num2,
	input  logic [alu_pkg::shamt_width-1:0]  shamt,
	input  logic                             grant,
	input  logic [alu_pkg::data_width-1:0]   alu_result,
	input  logic [alu_pkg::cmp_width-1:0]    alu_cmp_result,
	input  logic [alu_pkg::cmp_width-1:0]    alu_sig_cmp_result,
	input  logic                             alu_overflow,
	input  logic                             alu_op_invalid,
	output logic                             ack,
	output logic [alu_pkg::data_width-1:0]   result,
	output logic [alu_pkg::cmp_width-1:0]    cmp_result,
	output logic [alu_pkg::cmp_width-1:0]    sig_cmp_result,
	output logic                             overflow,
	output logic                             op_invalid,
	output logic                             alu_req
);

	typedef enum logic [1:0] {st_idle, st_wait, st_ack} state_t;

	state_t state;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			result <= '0;
			cmp_result <= '0;
			sig_cmp_result <= '0;
			overflow <= 1'b0;
			op_invalid <= 1'b0;
		end else begin
			case (state)
				st_idle: if (req) state <= st_wait;
				st_wait: begin
					if (grant) begin // ALU holds our command this cycle.
						state <= st_ack;
						result <= alu_result;
						cmp_result <= alu_cmp_result;
						sig_cmp_result <= alu_sig_cmp_result;
						overflow <= alu_overflow;
						op_invalid <= alu_op_invalid;
					end
				end
				st_ack: if (!req) state <= st_idle; // Release.
				default: state <= st_idle;
			endcase
		end
	end

	assign alu_req = (state == st_wait);
	assign ack = (state == st_ack);

	// Arbiter only grants a waiting port.
	grant_with_req: assert property (
		@(posedge clk) disable iff (reset)
		grant |-> alu_req
	) else $error("Grant seen while the port was not requesting.");

	no_ack_without_req: assert property (
		@(posedge clk) disable iff (reset)
		(!req && !ack) |=> !ack
	) else $error("ack rose while req was low.");

	// Requester must hold the command until it is served.
	cmd_stable: assert property (
		@(posedge clk) disable iff (reset)
		(alu_req && !grant) |=> $stable({op, num1, num2, shamt})
	) else $error("Command changed while waiting for the ALU.");

endmodule

// ==== rtl/alu_cluster.sv ====
module alu_cluster (
	input  logic                             clk,
	input  logic                             reset,
	input  logic                             a_req,
	input  logic [alu_pkg::op_width-1:0]     a_op,
	input  logic [alu_pkg::data_width-1:0]   a_num1,
	input  logic [alu_pkg::data_width-1:0]   a_num2,
	input  logic [alu_pkg::shamt_width-1:0]  a_shamt,
	output logic                             a_ack,
	output logic [alu_pkg::data_width-1:0]   a_result,
	output logic [alu_pkg::cmp_width-1:0]    a_cmp_result,
	output logic [alu_pkg::cmp_width-1:0]    a_sig_cmp_result,
	output logic                             a_overflow,
	output logic                             a_op_invalid,
	input  logic                             b_req,
	input  logic [alu_pkg::op_width-1:0]     b_op,
	input  logic [alu_pkg::data_width-1:0]   b_num1,
	input  logic [alu_pkg::data_width-1:0]   b_num2,
	input  logic [alu_pkg::shamt_width-1:0]  b_shamt,
	output logic                             b_ack,
	output logic [alu_pkg::data_width-1:0]   b_result,
	output logic [alu_pkg::cmp_width-1:0]    b_cmp_result,
	output logic [alu_pkg::cmp_width-1:0]    b_sig_cmp_result,
	output logic                             b_overflow,
	output logic                             b_op_invalid
);
	import alu_pkg::*;

	logic alu_req_a;
	logic alu_req_b;
	logic grant_a;
	logic grant_b;

	logic [op_width-1:0] alu_op;
	logic [data_width-1:0] alu_num1;
	logic [data_width-1:0] alu_num2;
	logic [shamt_width-1:0] alu_shamt;
	logic [data_width-1:0] alu_result;
	logic [cmp_width-1:0] alu_cmp_result;
	logic [cmp_width-1:0] alu_sig_cmp_result;
	logic alu_overflow;
	logic alu_op_invalid;

	//////////////////////////////////////////////////////////////////////
	// Command mux into the shared ALU
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		if (grant_a) begin
			alu_op = a_op;
			alu_num1 = a_num1;
			alu_num2 = a_num2;
			alu_shamt = a_shamt;
		end else if (grant_b) begin
			alu_op = b_op;
			alu_num1 = b_num1;
			alu_num2 = b_num2;
			alu_shamt = b_shamt;
		end else begin
			alu_op = '0; // Idle.
			alu_num1 = '0;
			alu_num2 = '0;
			alu_shamt = '0;
		end
	end

	alu_port port_a (
		.clk(clk),
		.reset(reset),
		.req(a_req),
		.op(a_op),
		.num1(a_num1),
		.num2(a_num2),
		.shamt(a_shamt),
		.grant(grant_a),
		.alu_result(alu_result),
		.alu_cmp_result(alu_cmp_result),
		.alu_sig_cmp_result(alu_sig_cmp_result),
		.alu_overflow(alu_overflow),
		.alu_op_invalid(alu_op_invalid),
		.ack(a_ack),
		.result(a_result),
		.cmp_result(a_cmp_result),
		.sig_cmp_result(a_sig_cmp_result),
		.overflow(a_overflow),
		.op_invalid(a_op_invalid),
		.alu_req(alu_req_a)
	);

	alu_port port_b (
		.clk(clk),
		.reset(reset),
		.req(b_req),
		.op(b_op),
		.num1(b_num1),
		.num2(b_num2),
		.shamt(b_shamt),
		.grant(grant_b),
		.alu_result(alu_result),
		.alu_cmp_result(alu_cmp_result),
		.alu_sig_cmp_result(alu_sig_cmp_result),
		.alu_overflow(alu_overflow),
		.alu_op_invalid(alu_op_invalid),
		.ack(b_ack),
		.result(b_result),
		.cmp_result(b_cmp_result),
		.sig_cmp_result(b_sig_cmp_result),
		.overflow(b_overflow),
		.op_invalid(b_op_invalid),
		.alu_req(alu_req_b)
	);

	alu_arbiter arbiter (
		.clk(clk),
		.reset(reset),
		.req_a(alu_req_a),
		.req_b(alu_req_b),
		.grant_a(grant_a),
		.grant_b(grant_b)
	);

	alu alu (
		.num1(alu_num1),
		.num2(alu_num2),
		.shamt(alu_shamt),
		.op(alu_op),
		.result(alu_result),
		.cmp_result(alu_cmp_result),
		.sig_cmp_result(alu_sig_cmp_result),
		.overflow(alu_overflow),
		.op_invalid(alu_op_invalid)
	);

endmodule

// ==== bench/alu_checker.sv ====
module alu_checker (
	input logic                            clk,
	input logic                            reset,
	input logic                            a_req,
	input logic [alu_pkg::op_width-1:0]    a_op,
	input logic [alu_pkg::data_width-1:0]  a_num1,
	input logic [alu_pkg::data_width-1:0]  a_num2,
	input logic [alu_pkg::shamt_width-1:0] a_shamt,
	input logic                            a_ack,
	input logic [alu_pkg::data_width-1:0]  a_result,
	input logic [alu_pkg::cmp_width-1:0]   a_cmp_result,
	input logic [alu_pkg::cmp_width-1:0]   a_sig_cmp_result,
	input logic                            a_overflow,
	input logic                            a_op_invalid,
	input logic                            b_req,
	input logic [alu_pkg::op_width-1:0]    b_op,
	input logic [alu_pkg::data_width-1:0]  b_num1,
	input logic [alu_pkg::data_width-1:0]  b_num2,
	input logic [alu_pkg::shamt_width-1:0] b_shamt,
	input logic                            b_ack,
	input logic [alu_pkg::data_width-1:0]  b_result,
	input logic [alu_pkg::cmp_width-1:0]   b_cmp_result,
	input logic [alu_pkg::cmp_width-1:0]   b_sig_cmp_result,
	input logic                            b_overflow,
	input logic                            b_op_invalid
);
	timeunit 1ns;
	timeprecision 1ps;
	import alu_pkg::*;

	int error_count = 0;
	int cmd_count = 0;
	logic a_ack_q = 1'b0;
	logic b_ack_q = 1'b0;
	logic a_req_q = 1'b0;
	logic b_req_q = 1'b0;
	logic reset_q = 1'b1;

	task automatic compare_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Mismatch at %0t ns on %s, expected %h, got %h", $time, name,
				expected, actual);
			error_count++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	task automatic model(input logic [op_width-1:0] op, input logic [31:0] a, b,
			input logic [4:0] sh, output logic [31:0] res, output logic [1:0] ucmp,
			output logic [1:0] scmp, output logic ovf, output logic inv);
		logic [4:0] amt;
		logic [63:0] ext;
		logic [31:0] sa;
		logic [31:0] sb;
		amt = (op == op_sllv || op == op_srlv || op == op_srav) ? a[4:0] : sh;
		sa = a ^ 32'h8000_0000; // Biased form orders like signed.
		sb = b ^ 32'h8000_0000;
		res = '0;
		ovf = 1'b0;
		inv = 1'b0;
		case (op)
			op_add: begin
				res = a + b;
				ovf = (res < a); // Carry out wraps the sum.
			end
			op_sub: begin
				res = a - b;
				ovf = (a < b); // Borrow.
			end
			op_and: res = a & b;
			op_or: res = a | b;
			op_not: res = ~a;
			op_xor: res = a ^ b;
			op_movz: res = a;
			op_nor: res = ~a & ~b;
			op_slt: res = {31'd0, sa < sb};
			op_sltu: res = {31'd0, a < b};
			op_sll, op_sllv: res = b << amt;
			op_srl, op_srlv: res = b >> amt;
			op_sra, op_srav: begin
				ext = {{32{b[31]}}, b} >> amt;
				res = ext[31:0];
			end
			default: inv = 1'b1;
		endcase
		ucmp = (a == b) ? cmp_equal : ((a < b) ? cmp_smaller : cmp_larger);
		scmp = (a == b) ? cmp_equal : ((sa < sb) ? cmp_smaller : cmp_larger);
	endtask

	task automatic check_channel(input string ch, input logic req_seen,
			input logic [4:0] op, input logic [31:0] n1, n2, input logic [4:0] sh,
			input logic [31:0] res, input logic [1:0] ucmp, scmp,
			input logic ovf, inv);
		logic [31:0] exp_res;
		logic [1:0] exp_ucmp;
		logic [1:0] exp_scmp;
		logic exp_ovf;
		logic exp_inv;
		if (!req_seen) begin
			$display("Channel %s raised ack at %0t ns with no request pending.", ch, $time);
			error_count++;
		end
		model(op, n1, n2, sh, exp_res, exp_ucmp, exp_scmp, exp_ovf, exp_inv);
		compare_value({ch, "_result"}, exp_res, res);
		compare_value({ch, "_cmp_result"}, 32'(exp_ucmp), 32'(ucmp));
		compare_value({ch, "_sig_cmp_result"}, 32'(exp_scmp), 32'(scmp));
		compare_value({ch, "_overflow"}, 32'(exp_ovf), 32'(ovf));
		compare_value({ch, "_op_invalid"}, 32'(exp_inv), 32'(inv));
		cmd_count++;
	endtask

	// Values read here are the ones before this edge.
	always @(posedge clk) begin
		if (reset_q && !reset) begin
			compare_value("a_ack", 32'd0, 32'(a_ack));
			compare_value("b_ack", 32'd0, 32'(b_ack));
			compare_value("a_result", 32'd0, a_result);
			compare_value("b_result", 32'd0, b_result);
		end
		if (!reset) begin
			if (a_ack && !a_ack_q) begin
				check_channel("a", a_req_q, a_op, a_num1, a_num2, a_shamt, a_result,
					a_cmp_result, a_sig_cmp_result, a_overflow, a_op_invalid);
			end
			if (b_ack && !b_ack_q) begin
				check_channel("b", b_req_q, b_op, b_num1, b_num2, b_shamt, b_result,
					b_cmp_result, b_sig_cmp_result, b_overflow, b_op_invalid);
			end
		end
		a_ack_q = a_ack;
		b_ack_q = b_ack;
		a_req_q = a_req;
		b_req_q = b_req;
		reset_q = reset;
	end

endmodule

// ==== bench/alu_cluster_tb.sv ====
module alu_cluster_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import alu_pkg::*;

	localparam int cmd_timeout = 20; // Cycles per handshake phase.

	logic clk = 1'b0;
	logic reset;
	logic a_req, b_req;
	logic [op_width-1:0] a_op, b_op;
	logic [data_width-1:0] a_num1, a_num2, b_num1, b_num2;
	logic [shamt_width-1:0] a_shamt, b_shamt;
	logic a_ack, b_ack;
	logic [data_width-1:0] a_result, b_result;
	logic [cmp_width-1:0] a_cmp_result, b_cmp_result;
	logic [cmp_width-1:0] a_sig_cmp_result, b_sig_cmp_result;
	logic a_overflow, b_overflow, a_op_invalid, b_op_invalid;

	logic [31:0] lcg_state = 32'd39378;
	int timeouts = 0;
	int cmds_issued = 0;
	int errs_seen = 0;
	int tests_passed = 0;
	int tests_failed = 0;

	alu_cluster dut (.*);

	alu_checker chk (.*);

	always #20 clk = ~clk;

	function logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function logic [31:0] rand_below(input logic [31:0] n);
		return (lcg_next() >> 16) % n; // Upper bits have the longer period.
	endfunction

	function logic [31:0] rand_word();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = lcg_next();
		lo = lcg_next();
		return {hi[31:16], lo[31:16]};
	endfunction

	function logic ack_of(input bit chan);
		return chan ? b_ack : a_ack;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Four-phase requester
	//////////////////////////////////////////////////////////////////////

	task automatic do_cmd(input bit chan, input logic [4:0] op, input logic [31:0] n1, n2,
			input logic [4:0] sh);
		int i;
		if (chan) begin
			{b_op, b_num1, b_num2, b_shamt} = {op, n1, n2, sh};
			b_req = 1'b1;
		end else begin
			{a_op, a_num1, a_num2, a_shamt} = {op, n1, n2, sh};
			a_req = 1'b1;
		end
		cmds_issued++;
		i = 0;
		do begin
			@(negedge clk);
			i++;
		end while (!ack_of(chan) && i < cmd_timeout);
		if (!ack_of(chan)) begin
			$display("Channel %s timed out waiting for ack to rise.", chan ? "B" : "A");
			timeouts++;
		end
		if (chan) b_req = 1'b0; // Command stays put until the next one.
		else a_req = 1'b0;
		i = 0;
		while (ack_of(chan) && i < cmd_timeout) begin
			@(negedge clk);
			i++;
		end
		if (ack_of(chan)) begin
			$display("Channel %s timed out waiting for ack to fall.", chan ? "B" : "A");
			timeouts++;
		end
	endtask

	task automatic issue_random(input bit chan, input logic [31:0] op_base,
			input logic [31:0] op_span, input bit force_equal);
		logic [31:0] op_r;
		logic [31:0] n1;
		logic [31:0] n2;
		logic [31:0] sh_r;
		logic [31:0] gap;
		gap = rand_below(4);
		repeat (gap) @(negedge clk);
		op_r = rand_below(op_span) + op_base;
		n1 = rand_word();
		n2 = force_equal ? n1 : rand_word();
		sh_r = rand_below(32);
		do_cmd(chan, op_r[4:0], n1, n2, sh_r[4:0]);
	endtask

	task automatic finish_test(input string name);
		int errs;
		errs = chk.error_count + timeouts - errs_seen;
		errs_seen = chk.error_count + timeouts;
		if (errs == 0) tests_passed++;
		else tests_failed++;
		$display("Test %s finished with %0d errors.", name, errs);
	endtask

	initial begin
		reset = 1'b1;
		{a_req, a_op, a_num1, a_num2, a_shamt} = '0;
		{b_req, b_op, b_num1, b_num2, b_shamt} = '0;
		repeat (4) @(negedge clk);
		reset = 1'b0;

		repeat (6) @(negedge clk); // Acks must stay low while idle.
		finish_test("reset and idle");

		repeat (40) issue_random(1'b0, 32'd0, 32'd10, 1'b0);
		finish_test("arithmetic and logic on A");

		repeat (40) issue_random(1'b0, 32'd10, 32'd6, 1'b0);
		finish_test("shifts");

		for (int i = 0; i < 32; i++) begin
			issue_random(i[0], 32'd0, 32'd16, i[1]); // Half with equal operands.
		end
		finish_test("compare outputs");

		repeat (20) issue_random(1'b0, 32'd16, 32'd16, 1'b0);
		finish_test("invalid opcodes");

		fork
			repeat (40) issue_random(1'b0, 32'd0, 32'd32, 1'b0);
			repeat (40) issue_random(1'b1, 32'd0, 32'd32, 1'b0);
		join
		repeat (2) @(negedge clk);
		finish_test("both channels under contention");

		if (chk.cmd_count != cmds_issued) begin
			$display("Checker saw %0d completed commands but %0d were issued.",
				chk.cmd_count, cmds_issued);
			tests_failed++;
		end
		$display("Tests passed %0d, failed %0d, commands checked %0d.", tests_passed,
			tests_failed, chk.cmd_count);
		if (tests_failed == 0 && chk.error_count == 0 && timeouts == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// ==== alu_cluster.f ====
rtl/alu_pkg.sv
rtl/alu.sv
rtl/alu_arbiter.sv
rtl/alu_port.sv
rtl/alu_cluster.sv
bench/alu_checker.sv
bench/alu_cluster_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the ALU cluster testbench with Verilator.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
	-f alu_cluster.f --top-module alu_cluster_tb; then
	echo "Verilator build failed."
	exit 1
fi

out=$(./obj_dir/Valu_cluster_tb)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status."
	exit 1
fi

if printf '%s\n' "$out" | grep -q "ALL CHECKS PASSED"; then
	exit 0
fi

echo "Pass message not found in simulation output."
exit 1
